// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = eeprom_tb
FILELIST  = verilog.f
LOG       = sim.log
RUNARGS   = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/eeprom_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_assert
    import eeprom_pkg::*;
(
    input logic    CLK,
    input logic    RESET,
    input logic    scl,
    input logic    sda_out,
    input logic    cmd_done,
    input logic    done,
    input bit_op_t op
);

    int fail_count = 0;

    // sda only moves under scl high as start (fall) or stop (rise)
    bus_legal: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_out != $past(sda_out))) |->
            (((op == op_start) && !sda_out) || ((op == op_stop) && sda_out)))
    else
    begin
        $error("sda changed while scl high outside start or stop");
        fail_count++;
    end

    cmd_done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        cmd_done |=> !cmd_done)
    else
    begin
        $error("cmd_done longer than one cycle");
        fail_count++;
    end

    done_pulse: assert property (@(posedge CLK) disable iff (RESET)
        done |=> !done)
    else
    begin
        $error("done longer than one cycle");
        fail_count++;
    end

    idle_after_reset: assert property (@(posedge CLK)
        $fell(RESET) |-> (scl && sda_out))
    else
    begin
        $error("bus not released after reset");
        fail_count++;
    end

endmodule

bind eeprom_master eeprom_assert i_assert (
    .CLK      (CLK),
    .RESET    (RESET),
    .scl      (scl),
    .sda_out  (sda_out),
    .cmd_done (cmd_done),
    .done     (done),
    .op       (cmd.op)
);

`default_nettype wire

// ==== bench/eeprom_bus_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_bus_model
    import eeprom_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_drive
);

    data_byte_t   mem [0:2**ADDR_W-1];
    logic         prev_scl;
    logic         prev_sda;
    logic [3:0]   bit_cnt;     // scl rising edges in the current byte
    data_byte_t   shreg;
    data_byte_t   out_byte;
    int           byte_idx;
    logic         sending;
    logic         pending_send;
    logic [2:0]   blk;
    eeprom_addr_t ptr;

    initial
    begin
        for (int a = 0; a < 2**ADDR_W; a++)
        begin
            mem[a] = data_byte_t'(a[7:0]) ^ 8'h5A;
        end
    end

    // bus sampled on CLK so both sides see settled levels
    always @(posedge CLK)
    begin
        if (RESET)
        begin
            prev_scl     = 1'b1;
            prev_sda     = 1'b1;
            bit_cnt      = '0;
            byte_idx     = 0;
            sending      = 1'b0;
            pending_send = 1'b0;
            sda_drive    = 1'b1;
        end
        else
        begin
            if (scl && prev_scl && prev_sda && !sda)
            begin
                bit_cnt      = '0;   // start or repeated start
                byte_idx     = 0;
                sending      = 1'b0;
                pending_send = 1'b0;
            end
            else if (scl && prev_scl && !prev_sda && sda)
            begin
                bit_cnt   = '0;   // stop
                byte_idx  = 0;
                sending   = 1'b0;
                sda_drive = 1'b1;
            end
            else if (scl && !prev_scl)
            begin
                if (!sending && (bit_cnt < 4'd8))
                begin
                    shreg = {shreg[6:0], sda};
                end
                bit_cnt = bit_cnt + 4'd1;
            end
            else if (!scl && prev_scl)
            begin
                if (bit_cnt == 4'd8)
                begin
                    if (sending)
                    begin
                        sending   = 1'b0;
                        sda_drive = 1'b1;   // master answers with nack
                    end
                    else
                    begin
                        case (byte_idx)
                            0:
                            begin
                                blk = shreg[3:1];
                                pending_send = shreg[0];
                            end
                            1:
                            begin
                                ptr = {blk, shreg};
                            end
                            default:
                            begin
                                mem[ptr] = shreg;
                            end
                        endcase
                        byte_idx  = byte_idx + 1;
                        sda_drive = 1'b0;   // ack
                    end
                end
                else if (bit_cnt == 4'd9)
                begin
                    bit_cnt   = '0;
                    sda_drive = 1'b1;
                    if (pending_send)
                    begin
                        pending_send = 1'b0;
                        sending      = 1'b1;
                        out_byte     = mem[ptr];
                        sda_drive    = out_byte[7];
                    end
                end
                else if (sending && (bit_cnt != 4'd0))
                begin
                    out_byte  = {out_byte[6:0], 1'b0};
                    sda_drive = out_byte[7];
                end
            end
            prev_scl = scl;
            prev_sda = sda;
        end
    end

endmodule

`default_nettype wire

// ==== bench/eeprom_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_checker
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  data_byte_t   wr_data,
    input  logic         done,
    input  data_byte_t   rd_data,
    input  logic [127:0] test_name,
    input  data_byte_t   exp_byte,
    input  logic         exp_known,
    output int           errors,
    output int           done_count,
    output int           accept_count
);

    data_byte_t   shadow [0:2**ADDR_W-1];
    logic         busy;
    logic         is_read;
    data_byte_t   predicted;
    data_byte_t   table_exp;
    logic         table_known;
    logic [127:0] name_q;
    int           busy_cycles;

    initial
    begin
        for (int a = 0; a < 2**ADDR_W; a++)
        begin
            shadow[a] = data_byte_t'(a[7:0]) ^ 8'h5A;
        end
    end

    always @(posedge CLK)
    begin
        if (RESET)
        begin
            busy         = 1'b0;
            errors       = 0;
            done_count   = 0;
            accept_count = 0;
            busy_cycles  = 0;
        end
        else if (done)
        begin
            done_count = done_count + 1;
            if (!busy)
            begin
                $display("ERROR: done pulse with no outstanding command");
                errors = errors + 1;
            end
            else if (is_read)
            begin
                if (rd_data !== predicted)
                begin
                    $display("MISMATCH %0s: expected %02h, actual %02h", name_q, predicted, rd_data);
                    errors = errors + 1;
                end
                if (table_known && (rd_data !== table_exp))
                begin
                    $display("MISMATCH %0s: expected %02h, actual %02h", name_q, table_exp, rd_data);
                    errors = errors + 1;
                end
            end
            busy = 1'b0;
        end
        else if (busy)
        begin
            busy_cycles = busy_cycles + 1;
            if (busy_cycles > 250)
            begin
                $display("ERROR: no done pulse for command of %0s", name_q);
                errors = errors + 1;
                busy   = 1'b0;
            end
        end
        else if (wr || rd)
        begin
            // accepted only while idle, wr wins
            busy         = 1'b1;
            busy_cycles  = 0;
            accept_count = accept_count + 1;
            is_read      = !wr;
            name_q       = test_name;
            table_exp    = exp_byte;
            table_known  = exp_known;
            if (wr)
            begin
                shadow[addr] = wr_data;
            end
            else
            begin
                predicted = shadow[addr];
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/eeprom_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_tb
    import eeprom_pkg::*;
;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_POKE   // read, with a wr strobe 20 cycles in
    } tb_op_t;

    localparam int N_ENTRIES = 18;
    localparam int CYCLE_LIMIT = N_ENTRIES * 200 + 100;

    logic         CLK;
    logic         RESET;
    logic         wr;
    logic         rd;
    eeprom_addr_t addr;
    data_byte_t   wr_data;
    logic         done;
    data_byte_t   rd_data;
    logic         scl;
    logic         sda_out;
    logic         sda_drive;
    logic         sda_bus;
    logic [127:0] cur_name;
    data_byte_t   cur_exp;
    logic         cur_known;
    int           errors;
    int           done_count;
    int           accept_count;
    int           cycles;
    int           n_fill;
    logic [31:0]  seed;

    tb_op_t       ops    [N_ENTRIES];
    eeprom_addr_t addrs  [N_ENTRIES];
    data_byte_t   datas  [N_ENTRIES];
    data_byte_t   exps   [N_ENTRIES];
    logic         knowns [N_ENTRIES];
    logic [127:0] names  [N_ENTRIES];

    assign sda_bus = sda_out & sda_drive;   // open drain

    eeprom_master i_dut (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .sda_in  (sda_bus),
        .done    (done),
        .rd_data (rd_data),
        .scl     (scl),
        .sda_out (sda_out)
    );

    eeprom_bus_model i_model (
        .CLK       (CLK),
        .RESET     (RESET),
        .scl       (scl),
        .sda       (sda_bus),
        .sda_drive (sda_drive)
    );

    eeprom_checker i_check (
        .CLK          (CLK),
        .RESET        (RESET),
        .wr           (wr),
        .rd           (rd),
        .addr         (addr),
        .wr_data      (wr_data),
        .done         (done),
        .rd_data      (rd_data),
        .test_name    (cur_name),
        .exp_byte     (cur_exp),
        .exp_known    (cur_known),
        .errors       (errors),
        .done_count   (done_count),
        .accept_count (accept_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic add_entry(input tb_op_t op, input eeprom_addr_t a, input data_byte_t d,
                             input data_byte_t e, input logic k, input logic [127:0] nm);
        ops[n_fill]    = op;
        addrs[n_fill]  = a;
        datas[n_fill]  = d;
        exps[n_fill]   = e;
        knowns[n_fill] = k;
        names[n_fill]  = nm;
        n_fill         = n_fill + 1;
    endtask

    task automatic build_table();
        n_fill = 0;
        add_entry(OP_WRITE, 11'h123, 8'hC3, 8'h00, 1'b0, 128'("wr_rd_write"));
        add_entry(OP_READ,  11'h123, 8'h00, 8'hC3, 1'b1, 128'("wr_rd_read"));
        add_entry(OP_READ,  11'h045, 8'h00, 8'h1F, 1'b1, 128'("unwritten_low"));
        add_entry(OP_READ,  11'h7FF, 8'h00, 8'hA5, 1'b1, 128'("unwritten_top"));
        add_entry(OP_WRITE, 11'h0A5, 8'h11, 8'h00, 1'b0, 128'("block0_write"));
        add_entry(OP_WRITE, 11'h5A5, 8'h22, 8'h00, 1'b0, 128'("block5_write"));
        add_entry(OP_READ,  11'h0A5, 8'h00, 8'h11, 1'b1, 128'("block0_read"));
        add_entry(OP_READ,  11'h5A5, 8'h00, 8'h22, 1'b1, 128'("block5_read"));
        add_entry(OP_POKE,  11'h0A5, 8'hEE, 8'h11, 1'b1, 128'("busy_poke"));
        add_entry(OP_READ,  11'h0A5, 8'h00, 8'h11, 1'b1, 128'("after_poke"));
        seed = 32'haaab;
        while (n_fill < N_ENTRIES)
        begin
            seed = lcg_next(seed);
            add_entry(seed[8] ? OP_WRITE : OP_READ, seed[26:16], seed[7:0],
                      8'h00, 1'b0, 128'("lcg_mixed"));
        end
    endtask

    task automatic run_entry(input int i);
        @(posedge CLK);
        #1;
        cur_name  = names[i];
        cur_exp   = exps[i];
        cur_known = knowns[i];
        addr      = addrs[i];
        wr_data   = datas[i];
        wr        = (ops[i] == OP_WRITE);
        rd        = (ops[i] != OP_WRITE);
        @(posedge CLK);
        #1;
        wr = 1'b0;
        rd = 1'b0;
        if (ops[i] == OP_POKE)
        begin
            repeat (19) @(posedge CLK);
            #1;
            wr = 1'b1;   // must be dropped
            @(posedge CLK);
            #1;
            wr = 1'b0;
        end
        while (!done)
        begin
            @(posedge CLK);
            #1;
        end
    endtask

    initial
    begin
        CLK = 1'b0;
        forever
        begin
            #2 CLK = ~CLK;
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge CLK);
            cycles = cycles + 1;
        end
        $display("timeout: run not finished after %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

    initial
    begin
        int bench_errors;
        int assert_fails;
        RESET     = 1'b1;
        wr        = 1'b0;
        rd        = 1'b0;
        addr      = '0;
        wr_data   = '0;
        cur_name  = '0;
        cur_exp   = '0;
        cur_known = 1'b0;
        bench_errors = 0;
        build_table();
        repeat (3) @(posedge CLK);
        #1;
        RESET = 1'b0;
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            run_entry(i);
        end
        repeat (10) @(posedge CLK);
        if ((done_count != N_ENTRIES) || (accept_count != N_ENTRIES))
        begin
            $display("ERROR: %0d commands accepted and %0d dones seen, %0d issued",
                     accept_count, done_count, N_ENTRIES);
            bench_errors = bench_errors + 1;
        end
        assert_fails = i_dut.i_assert.fail_count;
        $display("errors: checker %0d, bench %0d, assertions %0d; dones %0d",
                 errors, bench_errors, assert_fails, done_count);
        if ((errors == 0) && (bench_errors == 0) && (assert_fails == 0))
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/eeprom_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_master
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  data_byte_t   wr_data,
    input  logic         sda_in,
    output logic         done,
    output data_byte_t   rd_data,
    output logic         scl,
    output logic         sda_out
);

    bit_cmd_t   cmd;
    logic       cmd_valid;
    logic       cmd_done;
    data_byte_t rx_byte;

    eeprom_txn_sequencer i_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .done      (done),
        .rd_data   (rd_data)
    );

    // bus side, sda resolved outside as open drain
    serial_bit_engine i_engine (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .sda_in    (sda_in),
        .cmd_done  (cmd_done),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda_out   (sda_out)
    );

endmodule

`default_nettype wire

// ==== source/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;
    localparam int DATA_W = 8;

    typedef logic [ADDR_W-1:0] eeprom_addr_t;
    typedef logic [DATA_W-1:0] data_byte_t;

    localparam logic [3:0] DEVICE_TYPE = 4'b1010;   // leads every control byte
    localparam logic RW_WRITE = 1'b0;
    localparam logic RW_READ  = 1'b1;

    // one scl period in CLK cycles
    localparam int PHASES_PER_BIT = 4;
    localparam int PHASE_W = $clog2(PHASES_PER_BIT);

    typedef logic [PHASE_W-1:0] phase_t;

    localparam phase_t PH_DRIVE = phase_t'(0);                  // scl low, sda updated
    localparam phase_t PH_RISE  = phase_t'(PHASES_PER_BIT / 2); // scl high, sda sampled
    localparam phase_t PH_LAST  = phase_t'(PHASES_PER_BIT - 1);

    // 8 data bits plus the acknowledge slot
    typedef logic [$clog2(DATA_W+1)-1:0] bit_idx_t;

    localparam bit_idx_t ACK_BIT = bit_idx_t'(DATA_W);

    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_write_byte,
        op_read_byte
    } bit_op_t;

    typedef struct packed {
        bit_op_t    op;
        data_byte_t data;   // unused for start and stop
    } bit_cmd_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_restart,
        st_ctrl_read,
        st_data_read,
        st_stop,
        st_done
    } txn_state_t;

endpackage

`default_nettype wire

// ==== source/eeprom_txn_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_txn_sequencer
    import eeprom_pkg::*;
(
    input  logic         CLK,
    input  logic         RESET,
    input  logic         wr,
    input  logic         rd,
    input  eeprom_addr_t addr,
    input  data_byte_t   wr_data,
    input  logic         cmd_done,
    input  data_byte_t   rx_byte,
    output bit_cmd_t     cmd,
    output logic         cmd_valid,
    output logic         done,
    output data_byte_t   rd_data
);

    txn_state_t   state;
    txn_state_t   next_state;
    logic         is_read;
    eeprom_addr_t addr_q;
    data_byte_t   data_q;

    assign done = (state == st_done);

    // order of commands, read branch turns off after the address byte
    always_comb
    begin
        case (state)
            st_start:      next_state = st_ctrl_write;
            st_ctrl_write: next_state = st_addr_write;
            st_addr_write: next_state = is_read ? st_restart : st_data_write;
            st_data_write: next_state = st_stop;
            st_restart:    next_state = st_ctrl_read;
            st_ctrl_read:  next_state = st_data_read;
            st_data_read:  next_state = st_stop;
            st_stop:       next_state = st_done;
            default:       next_state = st_idle;
        endcase
    end

    always_comb
    begin
        cmd.op   = op_stop;
        cmd.data = '0;
        case (state)
            st_start, st_restart:
            begin
                cmd.op = op_start;
            end
            st_ctrl_write:
            begin
                cmd.op   = op_write_byte;
                cmd.data = {DEVICE_TYPE, addr_q[ADDR_W-1:DATA_W], RW_WRITE};
            end
            st_addr_write:
            begin
                cmd.op   = op_write_byte;
                cmd.data = addr_q[DATA_W-1:0];
            end
            st_data_write:
            begin
                cmd.op   = op_write_byte;
                cmd.data = data_q;
            end
            st_ctrl_read:
            begin
                cmd.op   = op_write_byte;
                cmd.data = {DEVICE_TYPE, addr_q[ADDR_W-1:DATA_W], RW_READ};
            end
            st_data_read:
            begin
                cmd.op = op_read_byte;
            end
            default:
            begin
                cmd.op = op_stop;   // st_stop, and idle where cmd_valid is low
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= st_idle;
            is_read   <= 1'b0;
            cmd_valid <= 1'b0;
            rd_data   <= '0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            case (state)
                st_idle:
                begin
                    if (wr || rd)
                    begin
                        is_read   <= !wr;   // wr wins a tie
                        state     <= st_start;
                        cmd_valid <= 1'b1;
                    end
                end
                st_done:
                begin
                    state <= st_idle;
                end
                default:
                begin
                    // one command in flight, next goes out the cycle after
                    if (cmd_done)
                    begin
                        state     <= next_state;
                        cmd_valid <= (next_state != st_done);
                    end
                end
            endcase
            if ((state == st_data_read) && cmd_done)
            begin
                rd_data <= rx_byte;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == st_idle) && (wr || rd))
        begin
            addr_q <= addr;
            data_q <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/serial_bit_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_bit_engine
    import eeprom_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  bit_cmd_t   cmd,
    input  logic       cmd_valid,
    input  logic       sda_in,
    output logic       cmd_done,
    output data_byte_t rx_byte,
    output logic       scl,
    output logic       sda_out
);

    bit_op_t    op_q;
    logic       busy;
    phase_t     phase;
    bit_idx_t   bit_cnt;
    data_byte_t shift_q;   // outgoing bits leave at the top, incoming enter at the bottom
    logic       is_cond;   // start or stop
    logic       last_bit;
    logic       bit_level;

    assign is_cond = (op_q == op_start) || (op_q == op_stop);

    // start and stop take a single bit period
    assign last_bit = is_cond || (bit_cnt == ACK_BIT);

    assign cmd_done = busy && (phase == PH_LAST) && last_bit;

    // scl idles high, low for the first half of every bit
    assign scl = !busy || phase[PHASE_W-1];

    assign rx_byte = shift_q;

    // level put on sda in the low half of the current bit
    always_comb
    begin
        case (op_q)
            op_start:
            begin
                bit_level = 1'b1;
            end
            op_stop:
            begin
                bit_level = 1'b0;
            end
            op_write_byte:
            begin
                if (bit_cnt == ACK_BIT)
                begin
                    bit_level = 1'b1;   // release for slave ack
                end
                else
                begin
                    bit_level = shift_q[DATA_W-1];
                end
            end
            default:
            begin
                bit_level = 1'b1;   // released while reading, then nack
            end
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            op_q    <= op_stop;
            phase   <= PH_DRIVE;
            bit_cnt <= '0;
            sda_out <= 1'b1;
        end
        else if (!busy)
        begin
            if (cmd_valid)
            begin
                busy    <= 1'b1;
                op_q    <= cmd.op;
                phase   <= PH_DRIVE;
                bit_cnt <= '0;
            end
        end
        else
        begin
            phase <= phase + 1'b1;   // wraps back to PH_DRIVE
            if (phase == PH_DRIVE)
            begin
                sda_out <= bit_level;
            end
            // start and stop flip sda while scl is high
            if ((phase == PH_RISE) && is_cond)
            begin
                sda_out <= !bit_level;
            end
            if (phase == PH_LAST)
            begin
                if (last_bit)
                begin
                    busy <= 1'b0;
                end
                else
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (cmd_valid && !busy)
        begin
            shift_q <= cmd.data;
        end
        else if (busy && !is_cond && (phase == PH_RISE) && (bit_cnt < ACK_BIT))
        begin
            shift_q <= {shift_q[DATA_W-2:0], sda_in};   // sample at scl high
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/eeprom_pkg.sv
source/serial_bit_engine.sv
source/eeprom_txn_sequencer.sv
source/eeprom_master.sv
bench/eeprom_bus_model.sv
bench/eeprom_checker.sv
bench/eeprom_assert.sv
bench/eeprom_tb.sv
